// ==== logic/sb_config_pkg.sv ====
package sb_config_pkg;

  // ------------------------------
  // Buffer geometry
  // ------------------------------

  localparam int sb_depth = 8;
  localparam int sb_index_width = 3;
  // Count runs 0 to sb_depth, plus room for two stores offered.
  localparam int sb_count_width = 4;

  // ------------------------------
  // Entry fields
  // ------------------------------

  // Addresses in the buffer are doubleword addresses.
  localparam int sb_addr_width = 26;
  localparam int sb_data_width = 64;
  localparam int sb_strb_width = 8;
  localparam int sb_offset_width = 3;

  // ------------------------------
  // AXI4-Lite
  // ------------------------------

  localparam int axi_addr_width = 32;
  // Upper zero bits when a doubleword address goes out as a byte address.
  localparam int axi_addr_pad = axi_addr_width - sb_addr_width - sb_offset_width;

endpackage

// ==== logic/sb_types_pkg.sv ====
package sb_types_pkg;

  // One buffered store, 98 bits.
  typedef struct packed {
    logic [sb_config_pkg::sb_addr_width-1:0] addr;
    logic [sb_config_pkg::sb_data_width-1:0] data;
    logic [sb_config_pkg::sb_strb_width-1:0] strb;
  } sb_entry_t;

  typedef enum logic {
    sb_load,
    sb_store
  } sb_kind_t;

  // One write port of the entry array.
  typedef struct packed {
    logic en;
    logic [sb_config_pkg::sb_index_width-1:0] index;
    sb_entry_t entry;
  } sb_write_t;

endpackage

// ==== logic/sb_entry_if.sv ====
`timescale 1ns/1ps

interface sb_entry_if;

  sb_types_pkg::sb_write_t write_0;
  sb_types_pkg::sb_write_t write_1;

  logic [sb_config_pkg::sb_index_width-1:0] read_index_0;
  logic [sb_config_pkg::sb_index_width-1:0] read_index_1;
  sb_types_pkg::sb_entry_t read_entry_0;
  sb_types_pkg::sb_entry_t read_entry_1;

  // Decode enqueues stores and points read port 1 at a forwarding hit.
  modport writer (
    output write_0,
    output write_1,
    output read_index_1
  );

  // Read port 0 always shows the head entry.
  modport drain (
    output read_index_0,
    input read_entry_0
  );

  modport lookup (
    input read_entry_1
  );

  modport storage (
    input write_0,
    input write_1,
    input read_index_0,
    input read_index_1,
    output read_entry_0,
    output read_entry_1
  );

endinterface

// ==== logic/sb_entry_array.sv ====
`timescale 1ns/1ps

module sb_entry_array (
  input logic clock,
  sb_entry_if.storage entries
);

  sb_types_pkg::sb_entry_t entry_mem [sb_config_pkg::sb_depth];

  // Port 1 is written last.
  always_ff @(posedge clock) begin
    if (entries.write_0.en) begin
      entry_mem[entries.write_0.index] <= entries.write_0.entry;
    end
    if (entries.write_1.en) begin
      entry_mem[entries.write_1.index] <= entries.write_1.entry;
    end
  end

  // Same-cycle bypass, write port 0 checked first.
  function automatic sb_types_pkg::sb_entry_t read_port(
    input logic [sb_config_pkg::sb_index_width-1:0] index
  );
    if (entries.write_0.en && entries.write_0.index == index) begin
      return entries.write_0.entry;
    end else if (entries.write_1.en && entries.write_1.index == index) begin
      return entries.write_1.entry;
    end
    return entry_mem[index];
  endfunction

  always_comb begin
    entries.read_entry_0 = read_port(entries.read_index_0);
    entries.read_entry_1 = read_port(entries.read_index_1);
  end

endmodule

// ==== logic/sb_request_decode.sv ====
`timescale 1ns/1ps

module sb_request_decode (
  input logic clock,
  input logic reset,
  input logic req_valid_0,
  input logic req_store_0,
  input logic [sb_config_pkg::axi_addr_width-1:0] req_addr_0,
  input logic [sb_config_pkg::sb_data_width-1:0] req_data_0,
  input logic [sb_config_pkg::sb_strb_width-1:0] req_strb_0,
  output logic req_ready_0,
  input logic req_valid_1,
  input logic req_store_1,
  input logic [sb_config_pkg::axi_addr_width-1:0] req_addr_1,
  input logic [sb_config_pkg::sb_data_width-1:0] req_data_1,
  input logic [sb_config_pkg::sb_strb_width-1:0] req_strb_1,
  output logic req_ready_1,
  sb_entry_if.writer entries,
  output logic [sb_config_pkg::sb_index_width-1:0] head,
  output logic have_entry,
  input logic pop,
  output logic load_miss_valid,
  output logic [sb_config_pkg::sb_addr_width-1:0] load_miss_addr,
  input logic load_done,
  output logic fwd_valid,
  output logic fwd_port,
  output logic miss_port
);

  typedef enum logic [1:0] {
    l_idle,
    l_lookup,
    l_miss
  } load_state_t;

  load_state_t load_state;
  logic [sb_config_pkg::sb_index_width-1:0] tail;
  logic [sb_config_pkg::sb_count_width-1:0] count;

  // Tags mirror the address and strobe coverage of each entry.
  logic [sb_config_pkg::sb_depth-1:0] tag_valid;
  logic [sb_config_pkg::sb_depth-1:0] tag_full;
  logic [sb_config_pkg::sb_addr_width-1:0] tag_addr [sb_config_pkg::sb_depth];

  logic [sb_config_pkg::sb_addr_width-1:0] load_addr;
  logic load_port;

  sb_types_pkg::sb_kind_t kind_0;
  sb_types_pkg::sb_kind_t kind_1;
  logic [sb_config_pkg::sb_addr_width-1:0] addr_0;
  logic [sb_config_pkg::sb_addr_width-1:0] addr_1;
  logic port_1_blocked;
  logic [sb_config_pkg::sb_count_width-1:0] offered;
  logic room;
  logic st_0;
  logic st_1;
  logic ld_0;
  logic ld_1;
  logic [sb_config_pkg::sb_index_width-1:0] index_1;

  logic hit_found;
  logic hit_full;
  logic [sb_config_pkg::sb_index_width-1:0] hit_index;
  logic [sb_config_pkg::sb_index_width-1:0] scan_index;

  // ------------------------------
  // Acceptance
  // ------------------------------

  always_comb begin
    kind_0 = req_store_0 ? sb_types_pkg::sb_store : sb_types_pkg::sb_load;
    kind_1 = req_store_1 ? sb_types_pkg::sb_store : sb_types_pkg::sb_load;
    addr_0 = req_addr_0[sb_config_pkg::sb_offset_width +: sb_config_pkg::sb_addr_width];
    addr_1 = req_addr_1[sb_config_pkg::sb_offset_width +: sb_config_pkg::sb_addr_width];
    // A load on the older port holds port 1 back for the cycle.
    port_1_blocked = req_valid_0 && kind_0 == sb_types_pkg::sb_load;
    offered = count
      + sb_config_pkg::sb_count_width'(req_valid_0 && kind_0 == sb_types_pkg::sb_store)
      + sb_config_pkg::sb_count_width'(req_valid_1 && kind_1 == sb_types_pkg::sb_store
                                       && !port_1_blocked);
    room = offered <= sb_config_pkg::sb_count_width'(sb_config_pkg::sb_depth);
    req_ready_0 = load_state == l_idle && room;
    req_ready_1 = load_state == l_idle && room && !port_1_blocked;
    st_0 = req_valid_0 && req_ready_0 && kind_0 == sb_types_pkg::sb_store;
    st_1 = req_valid_1 && req_ready_1 && kind_1 == sb_types_pkg::sb_store;
    ld_0 = req_valid_0 && req_ready_0 && kind_0 == sb_types_pkg::sb_load;
    ld_1 = req_valid_1 && req_ready_1 && kind_1 == sb_types_pkg::sb_load;
    index_1 = tail + sb_config_pkg::sb_index_width'(st_0);
  end

  always_comb begin
    entries.write_0.en = st_0;
    entries.write_0.index = tail;
    entries.write_0.entry.addr = addr_0;
    entries.write_0.entry.data = req_data_0;
    entries.write_0.entry.strb = req_strb_0;
    entries.write_1.en = st_1;
    entries.write_1.index = index_1;
    entries.write_1.entry.addr = addr_1;
    entries.write_1.entry.data = req_data_1;
    entries.write_1.entry.strb = req_strb_1;
  end

  // ------------------------------
  // Forwarding scan
  // ------------------------------

  // Youngest entry first, so the first match wins.
  always_comb begin
    hit_found = 1'b0;
    hit_full = 1'b0;
    hit_index = tail;
    scan_index = tail;
    for (int i = 1; i <= sb_config_pkg::sb_depth; i++) begin
      scan_index = tail - sb_config_pkg::sb_index_width'(i);
      if (!hit_found && tag_valid[scan_index] && tag_addr[scan_index] == load_addr) begin
        hit_found = 1'b1;
        hit_full = tag_full[scan_index];
        hit_index = scan_index;
      end
    end
  end

  assign entries.read_index_1 = hit_index;
  assign fwd_valid = load_state == l_lookup && hit_found && hit_full;
  assign fwd_port = load_port;
  assign miss_port = load_port;
  // Partial hits and misses go to memory once every store has drained.
  assign load_miss_valid = load_state == l_miss && count == '0;
  assign load_miss_addr = load_addr;
  assign have_entry = count != '0;

  // ------------------------------
  // State
  // ------------------------------

  always_ff @(posedge clock) begin
    if (!reset) begin
      load_state <= l_idle;
      head <= '0;
      tail <= '0;
      count <= '0;
      tag_valid <= '0;
    end else begin
      if (pop) begin
        head <= head + 1'b1;
        tag_valid[head] <= 1'b0;
      end
      if (st_0) begin
        tag_valid[tail] <= 1'b1;
      end
      if (st_1) begin
        tag_valid[index_1] <= 1'b1;
      end
      tail <= tail + sb_config_pkg::sb_index_width'(st_0)
        + sb_config_pkg::sb_index_width'(st_1);
      count <= count + sb_config_pkg::sb_count_width'(st_0)
        + sb_config_pkg::sb_count_width'(st_1) - sb_config_pkg::sb_count_width'(pop);
      case (load_state)
        l_idle: begin
          if (ld_0 || ld_1) begin
            load_state <= l_lookup;
          end
        end
        l_lookup: begin
          load_state <= (hit_found && hit_full) ? l_idle : l_miss;
        end
        l_miss: begin
          if (load_done) begin
            load_state <= l_idle;
          end
        end
        default: begin
          load_state <= l_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (st_0) begin
      tag_addr[tail] <= addr_0;
      tag_full[tail] <= &req_strb_0;
    end
    if (st_1) begin
      tag_addr[index_1] <= addr_1;
      tag_full[index_1] <= &req_strb_1;
    end
    if (ld_0 || ld_1) begin
      load_addr <= ld_0 ? addr_0 : addr_1;
      load_port <= ld_1;
    end
  end

endmodule

// ==== logic/sb_drain_execute.sv ====
`timescale 1ns/1ps

module sb_drain_execute (
  input logic clock,
  input logic reset,
  sb_entry_if.drain entries,
  input logic [sb_config_pkg::sb_index_width-1:0] head,
  input logic have_entry,
  output logic pop,
  input logic load_miss_valid,
  input logic [sb_config_pkg::sb_addr_width-1:0] load_miss_addr,
  output logic load_done,
  output logic [sb_config_pkg::sb_data_width-1:0] mem_rdata,
  output logic axi_awvalid,
  input logic axi_awready,
  output logic [sb_config_pkg::axi_addr_width-1:0] axi_awaddr,
  output logic [2:0] axi_awprot,
  output logic axi_wvalid,
  input logic axi_wready,
  output logic [sb_config_pkg::sb_data_width-1:0] axi_wdata,
  output logic [sb_config_pkg::sb_strb_width-1:0] axi_wstrb,
  input logic axi_bvalid,
  output logic axi_bready,
  output logic axi_arvalid,
  input logic axi_arready,
  output logic [sb_config_pkg::axi_addr_width-1:0] axi_araddr,
  output logic [2:0] axi_arprot,
  input logic axi_rvalid,
  output logic axi_rready,
  input logic [sb_config_pkg::sb_data_width-1:0] axi_rdata
);

  typedef enum logic [1:0] {
    s_idle,
    s_write,
    s_wait_b,
    s_read
  } drain_state_t;

  drain_state_t state;

  // Head entry stays put until pop, so the write channels read it directly.
  assign entries.read_index_0 = head;
  assign axi_awaddr = {{sb_config_pkg::axi_addr_pad{1'b0}}, entries.read_entry_0.addr,
                       {sb_config_pkg::sb_offset_width{1'b0}}};
  assign axi_wdata = entries.read_entry_0.data;
  assign axi_wstrb = entries.read_entry_0.strb;
  assign axi_awprot = 3'b000;
  assign axi_bready = 1'b1;

  assign axi_araddr = {{sb_config_pkg::axi_addr_pad{1'b0}}, load_miss_addr,
                       {sb_config_pkg::sb_offset_width{1'b0}}};
  assign axi_arprot = 3'b000;
  assign axi_rready = 1'b1;

  assign pop = state == s_wait_b && axi_bvalid;
  assign load_done = state == s_read && axi_rvalid;
  assign mem_rdata = axi_rdata;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= s_idle;
      axi_awvalid <= 1'b0;
      axi_wvalid <= 1'b0;
      axi_arvalid <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          // Writes first. A read only goes out once the buffer is empty.
          if (have_entry) begin
            axi_awvalid <= 1'b1;
            axi_wvalid <= 1'b1;
            state <= s_write;
          end else if (load_miss_valid) begin
            axi_arvalid <= 1'b1;
            state <= s_read;
          end
        end
        s_write: begin
          if (axi_awready) begin
            axi_awvalid <= 1'b0;
          end
          if (axi_wready) begin
            axi_wvalid <= 1'b0;
          end
          if ((axi_awready || !axi_awvalid) && (axi_wready || !axi_wvalid)) begin
            state <= s_wait_b;
          end
        end
        s_wait_b: begin
          if (axi_bvalid) begin
            state <= s_idle;
          end
        end
        s_read: begin
          if (axi_arready) begin
            axi_arvalid <= 1'b0;
          end
          if (axi_rvalid) begin
            state <= s_idle;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

endmodule

// ==== logic/sb_load_result.sv ====
`timescale 1ns/1ps

module sb_load_result (
  input logic clock,
  input logic reset,
  sb_entry_if.lookup entries,
  input logic fwd_valid,
  input logic fwd_port,
  input logic load_done,
  input logic [sb_config_pkg::sb_data_width-1:0] mem_rdata,
  input logic miss_port,
  output logic resp_valid_0,
  output logic resp_valid_1,
  output logic [sb_config_pkg::sb_data_width-1:0] resp_data_0,
  output logic [sb_config_pkg::sb_data_width-1:0] resp_data_1
);

  logic result_valid;
  logic result_port;
  logic [sb_config_pkg::sb_data_width-1:0] result;

  // Only one load is ever outstanding, so the two sources never collide.
  always_comb begin
    result_valid = fwd_valid || load_done;
    result_port = fwd_valid ? fwd_port : miss_port;
    result = fwd_valid ? entries.read_entry_1.data : mem_rdata;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      resp_valid_0 <= 1'b0;
      resp_valid_1 <= 1'b0;
    end else begin
      resp_valid_0 <= result_valid && !result_port;
      resp_valid_1 <= result_valid && result_port;
    end
  end

  // Each port keeps its last result.
  always_ff @(posedge clock) begin
    if (result_valid && !result_port) begin
      resp_data_0 <= result;
    end
    if (result_valid && result_port) begin
      resp_data_1 <= result;
    end
  end

endmodule

// ==== logic/store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer (
  input logic clock,
  input logic reset,
  input logic req_valid_0,
  input logic req_store_0,
  input logic [sb_config_pkg::axi_addr_width-1:0] req_addr_0,
  input logic [sb_config_pkg::sb_data_width-1:0] req_data_0,
  input logic [sb_config_pkg::sb_strb_width-1:0] req_strb_0,
  output logic req_ready_0,
  output logic resp_valid_0,
  output logic [sb_config_pkg::sb_data_width-1:0] resp_data_0,
  input logic req_valid_1,
  input logic req_store_1,
  input logic [sb_config_pkg::axi_addr_width-1:0] req_addr_1,
  input logic [sb_config_pkg::sb_data_width-1:0] req_data_1,
  input logic [sb_config_pkg::sb_strb_width-1:0] req_strb_1,
  output logic req_ready_1,
  output logic resp_valid_1,
  output logic [sb_config_pkg::sb_data_width-1:0] resp_data_1,
  output logic axi_awvalid,
  input logic axi_awready,
  output logic [sb_config_pkg::axi_addr_width-1:0] axi_awaddr,
  output logic [2:0] axi_awprot,
  output logic axi_wvalid,
  input logic axi_wready,
  output logic [sb_config_pkg::sb_data_width-1:0] axi_wdata,
  output logic [sb_config_pkg::sb_strb_width-1:0] axi_wstrb,
  input logic axi_bvalid,
  output logic axi_bready,
  output logic axi_arvalid,
  input logic axi_arready,
  output logic [sb_config_pkg::axi_addr_width-1:0] axi_araddr,
  output logic [2:0] axi_arprot,
  input logic axi_rvalid,
  output logic axi_rready,
  input logic [sb_config_pkg::sb_data_width-1:0] axi_rdata
);

  logic [sb_config_pkg::sb_index_width-1:0] head;
  logic have_entry;
  logic pop;
  logic load_miss_valid;
  logic [sb_config_pkg::sb_addr_width-1:0] load_miss_addr;
  logic load_done;
  logic [sb_config_pkg::sb_data_width-1:0] mem_rdata;
  logic fwd_valid;
  logic fwd_port;
  logic miss_port;

  sb_entry_if entries ();

  sb_entry_array u_entry_array (
    .clock(clock),
    .entries(entries.storage)
  );

  sb_request_decode u_request_decode (
    .clock(clock),
    .reset(reset),
    .req_valid_0(req_valid_0),
    .req_store_0(req_store_0),
    .req_addr_0(req_addr_0),
    .req_data_0(req_data_0),
    .req_strb_0(req_strb_0),
    .req_ready_0(req_ready_0),
    .req_valid_1(req_valid_1),
    .req_store_1(req_store_1),
    .req_addr_1(req_addr_1),
    .req_data_1(req_data_1),
    .req_strb_1(req_strb_1),
    .req_ready_1(req_ready_1),
    .entries(entries.writer),
    .head(head),
    .have_entry(have_entry),
    .pop(pop),
    .load_miss_valid(load_miss_valid),
    .load_miss_addr(load_miss_addr),
    .load_done(load_done),
    .fwd_valid(fwd_valid),
    .fwd_port(fwd_port),
    .miss_port(miss_port)
  );

  sb_drain_execute u_drain_execute (
    .clock(clock),
    .reset(reset),
    .entries(entries.drain),
    .head(head),
    .have_entry(have_entry),
    .pop(pop),
    .load_miss_valid(load_miss_valid),
    .load_miss_addr(load_miss_addr),
    .load_done(load_done),
    .mem_rdata(mem_rdata),
    .axi_awvalid(axi_awvalid),
    .axi_awready(axi_awready),
    .axi_awaddr(axi_awaddr),
    .axi_awprot(axi_awprot),
    .axi_wvalid(axi_wvalid),
    .axi_wready(axi_wready),
    .axi_wdata(axi_wdata),
    .axi_wstrb(axi_wstrb),
    .axi_bvalid(axi_bvalid),
    .axi_bready(axi_bready),
    .axi_arvalid(axi_arvalid),
    .axi_arready(axi_arready),
    .axi_araddr(axi_araddr),
    .axi_arprot(axi_arprot),
    .axi_rvalid(axi_rvalid),
    .axi_rready(axi_rready),
    .axi_rdata(axi_rdata)
  );

  sb_load_result u_load_result (
    .clock(clock),
    .reset(reset),
    .entries(entries.lookup),
    .fwd_valid(fwd_valid),
    .fwd_port(fwd_port),
    .load_done(load_done),
    .mem_rdata(mem_rdata),
    .miss_port(miss_port),
    .resp_valid_0(resp_valid_0),
    .resp_valid_1(resp_valid_1),
    .resp_data_0(resp_data_0),
    .resp_data_1(resp_data_1)
  );

endmodule

// ==== test/sb_axi_memory.sv ====
`timescale 1ns/1ps

module sb_axi_memory (
  input logic clock,
  input logic reset,
  input logic hold_writes,
  input logic axi_awvalid,
  output logic axi_awready,
  input logic [31:0] axi_awaddr,
  input logic axi_wvalid,
  output logic axi_wready,
  input logic [63:0] axi_wdata,
  input logic [7:0] axi_wstrb,
  output logic axi_bvalid,
  input logic axi_bready,
  input logic axi_arvalid,
  output logic axi_arready,
  input logic [31:0] axi_araddr,
  output logic axi_rvalid,
  input logic axi_rready,
  output logic [63:0] axi_rdata
);

  // One doubleword per index, filled by the testbench at time zero.
  logic [63:0] mem [256];
  logic [7:0] aw_index;
  logic [63:0] w_data_q;
  logic [7:0] w_strb_q;
  logic aw_got;
  logic w_got;
  logic [1:0] aw_delay;
  logic [1:0] w_delay;
  logic [1:0] ar_delay;

  always @(posedge clock) begin
    if (!reset) begin
      axi_awready <= 1'b0;
      axi_wready <= 1'b0;
      axi_bvalid <= 1'b0;
      axi_arready <= 1'b0;
      axi_rvalid <= 1'b0;
      aw_got <= 1'b0;
      w_got <= 1'b0;
      aw_delay <= 2'($urandom % 4);
      w_delay <= 2'($urandom % 4);
      ar_delay <= 2'($urandom % 4);
    end else begin
      axi_awready <= 1'b0;
      axi_wready <= 1'b0;
      axi_arready <= 1'b0;
      // Each channel counts down its own delay.
      if (axi_awvalid && axi_awready) begin
        aw_got <= 1'b1;
        aw_index <= axi_awaddr[10:3];
        aw_delay <= 2'($urandom % 4);
      end else if (axi_awvalid && !aw_got && !hold_writes) begin
        if (aw_delay == 2'd0) begin
          axi_awready <= 1'b1;
        end else begin
          aw_delay <= aw_delay - 2'd1;
        end
      end
      if (axi_wvalid && axi_wready) begin
        w_got <= 1'b1;
        w_data_q <= axi_wdata;
        w_strb_q <= axi_wstrb;
        w_delay <= 2'($urandom % 4);
      end else if (axi_wvalid && !w_got && !hold_writes) begin
        if (w_delay == 2'd0) begin
          axi_wready <= 1'b1;
        end else begin
          w_delay <= w_delay - 2'd1;
        end
      end
      if (aw_got && w_got && !axi_bvalid) begin
        for (int b = 0; b < 8; b++) begin
          if (w_strb_q[b]) begin
            mem[aw_index][8*b +: 8] <= w_data_q[8*b +: 8];
          end
        end
        axi_bvalid <= 1'b1;
        aw_got <= 1'b0;
        w_got <= 1'b0;
      end
      if (axi_bvalid && axi_bready) begin
        axi_bvalid <= 1'b0;
      end
      // Read data follows the address handshake by one cycle.
      if (axi_rvalid && axi_rready) begin
        axi_rvalid <= 1'b0;
      end
      if (axi_arvalid && axi_arready) begin
        axi_rdata <= mem[axi_araddr[10:3]];
        axi_rvalid <= 1'b1;
        ar_delay <= 2'($urandom % 4);
      end else if (axi_arvalid && !axi_rvalid) begin
        if (ar_delay == 2'd0) begin
          axi_arready <= 1'b1;
        end else begin
          ar_delay <= ar_delay - 2'd1;
        end
      end
    end
  end

endmodule

// ==== test/store_buffer_tb.sv ====
`timescale 1ns/1ps

module store_buffer_tb;

  localparam int timeout_cycles = 4000;
  localparam int path_any = 0;
  localparam int path_fwd = 1;
  localparam int path_mem = 2;

  logic clock;
  logic reset;
  logic req_valid_0;
  logic req_store_0;
  logic [31:0] req_addr_0;
  logic [63:0] req_data_0;
  logic [7:0] req_strb_0;
  logic req_ready_0;
  logic resp_valid_0;
  logic [63:0] resp_data_0;
  logic req_valid_1;
  logic req_store_1;
  logic [31:0] req_addr_1;
  logic [63:0] req_data_1;
  logic [7:0] req_strb_1;
  logic req_ready_1;
  logic resp_valid_1;
  logic [63:0] resp_data_1;
  logic axi_awvalid;
  logic axi_awready;
  logic [31:0] axi_awaddr;
  logic [2:0] axi_awprot;
  logic axi_wvalid;
  logic axi_wready;
  logic [63:0] axi_wdata;
  logic [7:0] axi_wstrb;
  logic axi_bvalid;
  logic axi_bready;
  logic axi_arvalid;
  logic axi_arready;
  logic [31:0] axi_araddr;
  logic [2:0] axi_arprot;
  logic axi_rvalid;
  logic axi_rready;
  logic [63:0] axi_rdata;
  logic hold_writes;

  logic [63:0] ref_mem [256];
  logic [31:0] aw_log [$];
  logic [7:0] strb_log [$];
  int resp_count [2];
  int resp_cycle [2];
  logic [63:0] resp_last [2];
  int cycle = 0;
  int value_errors = 0;
  int other_errors = 0;
  int stores_accepted = 0;
  int writes_done = 0;
  int reads_done = 0;
  logic first_request = 1'b0;

  store_buffer uut (.*);
  sb_axi_memory mem_model (.*);

  initial clock = 1'b0;
  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle == timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Bus and response monitor
  // ------------------------------

  always @(posedge clock) begin
    if (reset) begin
      if (axi_awvalid && axi_awready) begin
        aw_log.push_back(axi_awaddr);
      end
      if (axi_wvalid && axi_wready) begin
        strb_log.push_back(axi_wstrb);
      end
      if (axi_bvalid && axi_bready) begin
        writes_done++;
      end
      if (axi_rvalid && axi_rready) begin
        reads_done++;
      end
      // Unprivileged secure data access on both address channels.
      if (axi_awvalid) begin
        assert (axi_awprot == 3'b000)
        else report_value("Write protection", 64'(axi_awprot), 64'h0);
      end
      if (axi_arvalid) begin
        assert (axi_arprot == 3'b000)
        else report_value("Read protection", 64'(axi_arprot), 64'h0);
      end
      if (resp_valid_0) begin
        resp_count[0]++;
        resp_cycle[0] = cycle;
        resp_last[0] = resp_data_0;
      end
      if (resp_valid_1) begin
        resp_count[1]++;
        resp_cycle[1] = cycle;
        resp_last[1] = resp_data_1;
      end
      if (!first_request) begin
        assert (!axi_awvalid && !axi_wvalid && !axi_arvalid && !resp_valid_0 && !resp_valid_1)
        else report_other("A valid output rose after reset before any request");
      end
    end
  end

  function automatic logic [63:0] fill_word(input int index);
    return {32'(index) << 3, 32'h5eed_0000 ^ (32'(index) * 32'h0101_0101)};
  endfunction

  function automatic logic [63:0] merge_bytes(
    input logic [63:0] old_word,
    input logic [63:0] new_word,
    input logic [7:0] strb
  );
    logic [63:0] result;
    result = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic report_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    value_errors++;
    $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic report_other(input string what);
    other_errors++;
    $display("%s", what);
  endtask

  task automatic drive_port(
    input int port,
    input logic valid,
    input logic store,
    input int index,
    input logic [63:0] data,
    input logic [7:0] strb
  );
    if (port == 0) begin
      req_valid_0 = valid;
      req_store_0 = store;
      req_addr_0 = 32'(index) << 3;
      req_data_0 = data;
      req_strb_0 = strb;
    end else begin
      req_valid_1 = valid;
      req_store_1 = store;
      req_addr_1 = 32'(index) << 3;
      req_data_1 = data;
      req_strb_1 = strb;
    end
  endtask

  task automatic wait_accept(input int port);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clock);
      done = (port == 0) ? (req_valid_0 && req_ready_0) : (req_valid_1 && req_ready_1);
    end
  endtask

  task automatic record_store(input int index, input logic [63:0] data, input logic [7:0] strb);
    ref_mem[index] = merge_bytes(ref_mem[index], data, strb);
    stores_accepted++;
  endtask

  task automatic send_store(input int port, input int index, input logic [63:0] data,
                            input logic [7:0] strb);
    @(negedge clock);
    first_request = 1'b1;
    drive_port(port, 1'b1, 1'b1, index, data, strb);
    wait_accept(port);
    record_store(index, data, strb);
    @(negedge clock);
    drive_port(port, 1'b0, 1'b0, 0, '0, '0);
  endtask

  // Port 0 counts as older, so its bytes merge first.
  task automatic send_store_pair(
    input int index_0, input logic [63:0] data_0, input logic [7:0] strb_0,
    input int index_1, input logic [63:0] data_1, input logic [7:0] strb_1
  );
    @(negedge clock);
    first_request = 1'b1;
    drive_port(0, 1'b1, 1'b1, index_0, data_0, strb_0);
    drive_port(1, 1'b1, 1'b1, index_1, data_1, strb_1);
    wait_accept(1);
    assert (req_ready_0) else report_other("Port 0 store was not accepted with port 1");
    record_store(index_0, data_0, strb_0);
    record_store(index_1, data_1, strb_1);
    @(negedge clock);
    drive_port(0, 1'b0, 1'b0, 0, '0, '0);
    drive_port(1, 1'b0, 1'b0, 0, '0, '0);
  endtask

  task automatic check_load(input int port, input int index, input int path);
    int count_before;
    int other_before;
    int reads_before;
    int accept_cycle;
    logic [63:0] expected;
    @(negedge clock);
    first_request = 1'b1;
    expected = ref_mem[index];
    count_before = resp_count[port];
    other_before = resp_count[1-port];
    reads_before = reads_done;
    drive_port(port, 1'b1, 1'b0, index, '0, '0);
    wait_accept(port);
    accept_cycle = cycle;
    @(negedge clock);
    drive_port(port, 1'b0, 1'b0, 0, '0, '0);
    while (resp_count[port] == count_before) begin
      @(negedge clock);
    end
    assert (resp_last[port] == expected) else report_value("Load data", resp_last[port], expected);
    assert (resp_count[1-port] == other_before)
    else report_other("A load response appeared on the other port");
    if (path == path_fwd) begin
      assert (resp_cycle[port] - accept_cycle == 2)
      else report_other("Forwarded load did not respond two cycles after acceptance");
    end else if (path == path_mem) begin
      assert (reads_done == reads_before + 1) else report_other("Load did not read memory");
    end
  endtask

  task automatic wait_drained();
    @(negedge clock);
    while (writes_done != stores_accepted) begin
      @(negedge clock);
    end
  endtask

  task automatic check_memory(input int index);
    assert (mem_model.mem[index] == ref_mem[index])
    else report_value("Memory word", mem_model.mem[index], ref_mem[index]);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic forward_full_store();
    @(negedge clock);
    hold_writes = 1'b1;
    send_store(0, 10, 64'h1122_3344_5566_7788, 8'hff);
    check_load(1, 10, path_fwd);
    @(negedge clock);
    hold_writes = 1'b0;
    wait_drained();
    check_memory(10);
  endtask

  task automatic merge_partial_stores();
    send_store(0, 20, 64'haaaa_aaaa_aaaa_aaaa, 8'h0f);
    send_store(1, 20, 64'hbbbb_bbbb_bbbb_bbbb, 8'h3c);
    check_load(0, 20, path_mem);
    wait_drained();
    check_memory(20);
  endtask

  task automatic load_unstored_words();
    check_load(0, 100, path_mem);
    check_load(1, 101, path_mem);
  endtask

  task automatic store_same_cycle();
    send_store_pair(30, 64'h0000_0000_dead_0000, 8'hff, 30, 64'h1111_1111_beef_1111, 8'hff);
    check_load(0, 30, path_any);
    send_store_pair(31, 64'h3131_3131_3131_3131, 8'hff, 32, 64'h3232_3232_3232_3232, 8'hf0);
    wait_drained();
    check_memory(30);
    check_memory(31);
    check_memory(32);
  endtask

  task automatic fill_under_backpressure();
    logic [7:0] exp_strb [8];
    int aw_start;
    int w_start;
    @(negedge clock);
    hold_writes = 1'b1;
    aw_start = aw_log.size();
    w_start = strb_log.size();
    for (int i = 0; i < 8; i++) begin
      exp_strb[i] = 8'($urandom) | 8'h01;
      send_store(i % 2, 40 + i, {$urandom, $urandom}, exp_strb[i]);
    end
    // A ninth store has no room.
    @(negedge clock);
    drive_port(0, 1'b1, 1'b1, 48, 64'h0, 8'hff);
    repeat (4) begin
      @(posedge clock);
      assert (!req_ready_0 && !req_ready_1) else report_other("Readies stayed high when full");
    end
    @(negedge clock);
    drive_port(0, 1'b0, 1'b0, 0, '0, '0);
    hold_writes = 1'b0;
    wait_drained();
    assert (aw_log.size() == aw_start + 8 && strb_log.size() == w_start + 8)
    else report_other("Memory did not see eight writes after release");
    for (int i = 0; i < 8 && aw_start + i < aw_log.size() && w_start + i < strb_log.size();
         i++) begin
      assert (aw_log[aw_start+i] == 32'(40 + i) << 3)
      else report_value("Write address", 64'(aw_log[aw_start+i]), 64'(32'(40 + i) << 3));
      assert (strb_log[w_start+i] == exp_strb[i])
      else report_value("Write strobe", 64'(strb_log[w_start+i]), 64'(exp_strb[i]));
      check_memory(40 + i);
    end
  endtask

  task automatic load_while_draining();
    send_store(0, 60, 64'h6060_6060_6060_6060, 8'h0f);
    send_store(1, 61, 64'h6161_6161_6161_6161, 8'hff);
    send_store(0, 60, 64'h0606_0606_0606_0606, 8'hf0);
    check_load(1, 60, path_mem);
    wait_drained();
    check_memory(60);
    check_memory(61);
  endtask

  initial begin
    void'($urandom(8));
    reset = 1'b0;
    hold_writes = 1'b0;
    drive_port(0, 1'b0, 1'b0, 0, '0, '0);
    drive_port(1, 1'b0, 1'b0, 0, '0, '0);
    resp_count[0] = 0;
    resp_count[1] = 0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i);
      mem_model.mem[i] = ref_mem[i];
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    repeat (4) @(negedge clock);
    forward_full_store();
    merge_partial_stores();
    load_unstored_words();
    store_same_cycle();
    fill_under_backpressure();
    load_while_draining();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== store_buffer.f ====
logic/sb_config_pkg.sv
logic/sb_types_pkg.sv
logic/sb_entry_if.sv
logic/sb_entry_array.sv
logic/sb_request_decode.sv
logic/sb_drain_execute.sv
logic/sb_load_result.sv
logic/store_buffer.sv
test/sb_axi_memory.sv
test/store_buffer_tb.sv

// ==== Bender.yml ====
package:
  name: store_buffer

sources:
  - logic/sb_config_pkg.sv
  - logic/sb_types_pkg.sv
  - logic/sb_entry_if.sv
  - logic/sb_entry_array.sv
  - logic/sb_request_decode.sv
  - logic/sb_drain_execute.sv
  - logic/sb_load_result.sv
  - logic/store_buffer.sv
  - target: test
    files:
      - test/sb_axi_memory.sv
      - test/store_buffer_tb.sv
